// File: run_sim.sh
#!/usr/bin/env bash
# Build the transport bridge testbench with Verilator, run it,
# and decide the result from the simulation log.

cd "$(dirname "$0")" || exit 1

TOP=tb_sata_transport_bridge
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --assert \
    -f verilog.f \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qF "*** PASSED ***" "$LOG"
status=$?
if [ $status -ne 0 ]; then
    echo "pass message not found in $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

// File: source/d2h_fis_tagger.sv
// Device-to-host FIS tagger
// Tags each received dword for the D2H FIFO: first dword of a FIS as
// head, the rest as data. After done, or the delayed invalidate, one
// closing R_OK or R_ERR entry with zero payload is pushed.
// Makes d2h_many for the host and ll_rx_busy for the link.

`include "sata_bridge_settings.svh"
`default_nettype none

module d2h_fis_tagger
    import sata_bridge_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`SATA_DWORD_WIDTH-1:0] ll_rx_data,
    input  logic [`SATA_MASK_WIDTH-1:0]  ll_rx_mask,
    input  logic                          ll_rx_valid,   // one dword per cycle
    input  rx_events_t                    ll_rx_events,
    input  fill_t                         fill,          // D2H FIFO fill
    output logic                          wr,            // D2H FIFO push
    output fifo_word_t                    wr_word,
    output logic                          d2h_many,
    output logic                          ll_rx_busy
);

    d2h_tag_e rx_tag;        // tag for the next entry
    logic     invalidate_r;  // lets the last dword through first
    logic     fis_end;
    logic     close_r;       // push closing entry now

    assign fis_end = ll_rx_events.done || invalidate_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            invalidate_r <= 1'b0;
        end else begin
            invalidate_r <= ll_rx_events.invalidate;
        end
    end

    // head -> data -> R_OK / R_ERR
    always_ff @(posedge clk) begin
        if (rst || ll_rx_events.start) begin
            rx_tag <= D2H_FIS_HEAD;
        end else if (ll_rx_valid) begin
            rx_tag <= D2H_DMA;
        end else if (fis_end) begin
            rx_tag <= invalidate_r ? D2H_R_ERR : D2H_R_OK;
        end
    end

    // once per FIS, only after body data
    always_ff @(posedge clk) begin
        if (rst) begin
            close_r <= 1'b0;
        end else begin
            close_r <= fis_end && (rx_tag == D2H_DMA);
        end
    end

    assign wr           = ll_rx_valid || close_r;
    assign wr_word.tag  = rx_tag;
    assign wr_word.mask = close_r ? '0 : ll_rx_mask;   // closing entry carries no payload
    assign wr_word.data = close_r ? '0 : ll_rx_data;

    assign d2h_many   = fill >= fill_t'(`SATA_D2H_MANY_FILL);
    assign ll_rx_busy = fill >= fill_t'(`SATA_D2H_BUSY_FILL);   // link throttles

    // link must be quiet when the FIS is closed
    close_not_with_data_a : assert property (
        @(posedge clk) disable iff (rst)
        close_r |-> !ll_rx_valid
    ) else $error("d2h_fis_tagger: closing entry collides with ll_rx_valid");

endmodule

`default_nettype wire

// File: source/h2d_frame_scheduler.sv
// Host-to-device frame scheduler
// Watches the host write side of the H2D FIFO. Once a FIS head is in,
// the frame request to the link goes up when the FIS last dword is
// written or enough dwords are buffered, and drops after the link ack.
// Also decodes ll_tx_last from the FIFO head and makes h2d_ready.

`include "sata_bridge_settings.svh"
`default_nettype none

module h2d_frame_scheduler
    import sata_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  fifo_word_t h2d_word,      // word being written by host
    input  logic       h2d_valid,
    input  fifo_word_t head_word,     // current FIFO head
    input  fill_t      fill,          // H2D FIFO fill
    input  logic       ll_frame_ack,  // one-cycle ack from link
    output logic       ll_frame_req,
    output logic       ll_tx_last,
    output logic       h2d_ready
);

    logic head_wr;     // FIS head written this cycle
    logic last_wr;     // FIS last written this cycle
    logic enough_fill;
    logic pending;     // FIS started, request not yet raised

    assign head_wr     = h2d_valid && (h2d_tag_e'(h2d_word.tag) == H2D_FIS_HEAD);
    assign last_wr     = h2d_valid && (h2d_tag_e'(h2d_word.tag) == H2D_FIS_LAST);
    assign enough_fill = fill >= fill_t'(`SATA_XMIT_START_FILL);

    // pending drops once the request is up
    always_ff @(posedge clk) begin
        if (rst || ll_frame_req) begin
            pending <= 1'b0;
        end else if (head_wr) begin
            pending <= 1'b1;
        end
    end

    // whole FIS buffered, or enough to keep the link fed
    always_ff @(posedge clk) begin
        if (rst) begin
            ll_frame_req <= 1'b0;
        end else if (pending && (last_wr || enough_fill)) begin
            ll_frame_req <= 1'b1;
        end else if (ll_frame_ack) begin
            ll_frame_req <= 1'b0;  // falls the cycle after ack
        end
    end

    assign ll_tx_last = h2d_tag_e'(head_word.tag) == H2D_FIS_LAST;   // head closes FIS
    assign h2d_ready  = fill < fill_t'(`SATA_H2D_READY_LIMIT);      // 8 slots of slack

    // link only acks a request that is outstanding
    frame_ack_with_req_a : assert property (
        @(posedge clk) disable iff (rst)
        ll_frame_ack |-> ll_frame_req
    ) else $error("h2d_frame_scheduler: ll_frame_ack without ll_frame_req");

endmodule

`default_nettype wire

// File: source/sata_bridge_pkg.sv
// SATA transport bridge types
// FIFO entry layout, per-direction tag encodings, fill count
// and the receive event pulses coming from the link layer

`include "sata_bridge_settings.svh"
`default_nettype none

package sata_bridge_pkg;

    // one 36-bit FIFO entry with the tag on top
    typedef struct packed {
        logic [1:0]                    tag;   // h2d_tag_e or d2h_tag_e
        logic [`SATA_MASK_WIDTH-1:0]  mask;
        logic [`SATA_DWORD_WIDTH-1:0] data;
    } fifo_word_t;

    typedef enum logic [1:0] {
        H2D_FIS_DATA = 2'd0,  // body dword
        H2D_FIS_HEAD = 2'd1,  // first dword of FIS
        H2D_FIS_LAST = 2'd2   // closes the FIS
    } h2d_tag_e;

    typedef enum logic [1:0] {
        D2H_DMA      = 2'd0,  // body dword
        D2H_FIS_HEAD = 2'd1,  // first dword of FIS
        D2H_R_OK     = 2'd2,  // closing entry, data ignored
        D2H_R_ERR    = 2'd3   // closing entry after invalidate
    } d2h_tag_e;

    typedef logic [`SATA_FIFO_ADDR_WIDTH:0] fill_t;  // 0..512 inclusive

    // single-cycle pulses from link receive side
    typedef struct packed {
        logic start;       // before first dword
        logic done;        // good frame end
        logic invalidate;  // bad CRC or aborted frame
    } rx_events_t;

endpackage

`default_nettype wire

// File: source/sata_bridge_settings.svh
// SATA transport bridge settings
// FIFO geometry, dword and mask widths, and the fill thresholds
// used by the transmit scheduler and the receive tagger

`ifndef SATA_BRIDGE_SETTINGS_SVH
`define SATA_BRIDGE_SETTINGS_SVH

`default_nettype none

`define SATA_FIFO_ADDR_WIDTH  9    // 512 entries per FIFO
`define SATA_DWORD_WIDTH      32   // payload dword
`define SATA_MASK_WIDTH       2    // word mask, normally all ones

`define SATA_XMIT_START_FILL  64   // start frame before FIS last is in
`define SATA_H2D_READY_LIMIT  504  // h2d_ready low from here up
`define SATA_D2H_MANY_FILL    8    // d2h_many high from here up
`define SATA_D2H_BUSY_FILL    448  // throttle link from here up

`default_nettype wire

`endif

// File: source/sata_dword_fifo.sv
// SATA dword FIFO
// Same-clock FIFO of tagged dwords with a first-word-fall-through read.
// The head entry sits on rd_word whenever nempty is high.
// fill counts the stored entries and lags a write or a pop by one cycle.
// flush empties the FIFO just like rst.

`include "sata_bridge_settings.svh"
`default_nettype none

module sata_dword_fifo
    import sata_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,    // software flush
    input  logic       wr,       // push wr_word
    input  fifo_word_t wr_word,
    input  logic       rd,       // pop head
    output fifo_word_t rd_word,  // head entry
    output logic       nempty,
    output fill_t      fill
);

    localparam int DEPTH = 1 << `SATA_FIFO_ADDR_WIDTH;

    fifo_word_t                       mem [DEPTH];  // payload storage
    logic [`SATA_FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [`SATA_FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic                             full;

    // storage write
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // pointers wrap naturally at DEPTH
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // simultaneous push and pop leave fill alone
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fill <= '0;
        end else begin
            case ({wr, rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign rd_word = mem[rd_ptr];                   // fall-through head
    assign nempty  = |fill;
    assign full    = fill[`SATA_FIFO_ADDR_WIDTH];   // only set at DEPTH

    // writer must watch its ready or busy flag
    fifo_no_overflow_a : assert property (
        @(posedge clk) disable iff (rst || flush)
        wr |-> !full
    ) else $error("sata_dword_fifo: write while full");

    // reader must only pop a valid head
    fifo_no_underflow_a : assert property (
        @(posedge clk) disable iff (rst || flush)
        rd |-> nempty
    ) else $error("sata_dword_fifo: read while empty");

endmodule

`default_nettype wire

// File: source/sata_transport_bridge.sv
// SATA transport bridge
// Buffering between host DMA logic and the SATA link layer.
// H2D FIFO with frame scheduling toward the link transmit side,
// D2H FIFO with FIS tagging from the link receive side.
// pcmd_st_cleared flushes both FIFOs.

`include "sata_bridge_settings.svh"
`default_nettype none

module sata_transport_bridge
    import sata_bridge_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pcmd_st_cleared,  // PxCMD.ST cleared by software

    // host write side
    input  fifo_word_t                    h2d_word,         // tag as h2d_tag_e
    input  logic                          h2d_valid,
    output logic                          h2d_ready,

    // link transmit side
    output fifo_word_t                    ll_tx_word,
    output logic                          ll_tx_valid,
    output logic                          ll_tx_last,
    input  logic                          ll_tx_strobe,     // pop, only while valid
    output logic                          ll_frame_req,
    input  logic                          ll_frame_ack,

    // link receive side
    input  logic [`SATA_DWORD_WIDTH-1:0] ll_rx_data,
    input  logic [`SATA_MASK_WIDTH-1:0]  ll_rx_mask,
    input  logic                          ll_rx_valid,
    input  rx_events_t                    ll_rx_events,
    output logic                          ll_rx_busy,

    // host read side
    output fifo_word_t                    d2h_word,         // tag as d2h_tag_e
    output logic                          d2h_valid,
    output logic                          d2h_many,
    input  logic                          d2h_ready
);

    fill_t      h2d_fill;
    fill_t      d2h_fill;
    logic       d2h_rd;      // host pop
    logic       d2h_wr;      // tagger push
    fifo_word_t d2h_wr_word;

    assign d2h_rd = d2h_valid && d2h_ready;

    sata_dword_fifo h2d_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .flush   (pcmd_st_cleared),
        .wr      (h2d_valid),
        .wr_word (h2d_word),
        .rd      (ll_tx_strobe),
        .rd_word (ll_tx_word),
        .nempty  (ll_tx_valid),
        .fill    (h2d_fill)
    );

    h2d_frame_scheduler h2d_frame_scheduler_i (
        .clk          (clk),
        .rst          (rst),
        .h2d_word     (h2d_word),
        .h2d_valid    (h2d_valid),
        .head_word    (ll_tx_word),   // FIFO head for last decode
        .fill         (h2d_fill),
        .ll_frame_ack (ll_frame_ack),
        .ll_frame_req (ll_frame_req),
        .ll_tx_last   (ll_tx_last),
        .h2d_ready    (h2d_ready)
    );

    d2h_fis_tagger d2h_fis_tagger_i (
        .clk          (clk),
        .rst          (rst),
        .ll_rx_data   (ll_rx_data),
        .ll_rx_mask   (ll_rx_mask),
        .ll_rx_valid  (ll_rx_valid),
        .ll_rx_events (ll_rx_events),
        .fill         (d2h_fill),
        .wr           (d2h_wr),
        .wr_word      (d2h_wr_word),
        .d2h_many     (d2h_many),
        .ll_rx_busy   (ll_rx_busy)
    );

    sata_dword_fifo d2h_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .flush   (pcmd_st_cleared),
        .wr      (d2h_wr),
        .wr_word (d2h_wr_word),
        .rd      (d2h_rd),
        .rd_word (d2h_word),
        .nempty  (d2h_valid),
        .fill    (d2h_fill)
    );

endmodule

`default_nettype wire

// File: testbench/tb_sata_transport_tasks.svh
// Traffic tasks for the transport bridge testbench
// Send and drain H2D and D2H FIS traffic, handle the frame handshake
// and the flush, and check values against the expected queues

`ifndef TB_SATA_TRANSPORT_TASKS_SVH
`define TB_SATA_TRANSPORT_TASKS_SVH

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
        $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_word(input string name, input fifo_word_t got, input fifo_word_t exp);
    checks++;
    assert (got === exp) else begin
        $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic report_timeout(input string what);
    $display("timeout at %0t, gave up waiting for %s", $time, what);
    errors++;
endtask

// back-to-back host writes that note when the request shows up
task automatic send_h2d_fis(input int len, input logic [1:0] last_tag, output int first_req);
    fifo_word_t  w;
    logic [31:0] r;
    first_req = -1;
    for (int i = 0; i < len; i++) begin
        r      = $random(seed);
        w.data = r;
        w.mask = 2'b11;
        w.tag  = (i == 0) ? H2D_FIS_HEAD : ((i == len - 1) ? last_tag : H2D_FIS_DATA);
        @(posedge clk);
        h2d_word  <= w;
        h2d_valid <= 1'b1;
        tx_exp_q.push_back(w);
        @(negedge clk);
        check_bit("h2d_ready", h2d_ready, 1'b1);
        if (ll_frame_req && (first_req < 0)) begin
            first_req = i;
        end
    end
    @(posedge clk);
    h2d_valid <= 1'b0;
endtask

task automatic wait_frame_req(input logic level);
    int guard;
    guard = 0;
    @(negedge clk);
    while ((ll_frame_req !== level) && (guard < WAIT_LIMIT)) begin
        @(negedge clk);
        guard++;
    end
    if (guard >= WAIT_LIMIT) begin
        report_timeout(level ? "ll_frame_req to rise" : "ll_frame_req to fall");
    end
endtask

task automatic ack_frame();
    @(posedge clk);
    ll_frame_ack <= 1'b1;  // one-cycle ack
    @(posedge clk);
    ll_frame_ack <= 1'b0;
endtask

// pop one word every other cycle
task automatic drain_h2d();
    fifo_word_t exp;
    int         guard;
    while (tx_exp_q.size() > 0) begin
        exp   = tx_exp_q.pop_front();
        guard = 0;
        @(negedge clk);
        while (!ll_tx_valid && (guard < WAIT_LIMIT)) begin
            @(negedge clk);
            guard++;
        end
        if (guard >= WAIT_LIMIT) begin
            report_timeout("ll_tx_valid");
            tx_exp_q.delete();
            break;
        end
        check_word("ll_tx_word", ll_tx_word, exp);
        check_bit("ll_tx_last", ll_tx_last, exp.tag == H2D_FIS_LAST);
        @(posedge clk);
        ll_tx_strobe <= 1'b1;
        @(posedge clk);
        ll_tx_strobe <= 1'b0;
    end
    @(negedge clk);
    check_bit("ll_tx_valid", ll_tx_valid, 1'b0);
endtask

// start pulse, len dwords, then done or invalidate
task automatic recv_d2h_fis(input int len, input logic inval, input logic [1:0] close_tag);
    fifo_word_t  w;
    logic [31:0] r;
    logic [31:0] m;
    @(negedge clk);
    check_bit("ll_rx_busy", ll_rx_busy, 1'b0);
    @(posedge clk);
    ll_rx_events.start <= 1'b1;
    @(posedge clk);
    ll_rx_events <= '0;
    for (int i = 0; i < len; i++) begin
        r      = $random(seed);
        m      = $random(seed);
        w.data = r;
        w.mask = m[1:0];
        w.tag  = (i == 0) ? D2H_FIS_HEAD : D2H_DMA;
        @(posedge clk);
        ll_rx_data  <= r;
        ll_rx_mask  <= m[1:0];
        ll_rx_valid <= 1'b1;
        rx_exp_q.push_back(w);
    end
    @(posedge clk);
    ll_rx_valid <= 1'b0;
    @(posedge clk);
    ll_rx_events.done       <= !inval;
    ll_rx_events.invalidate <= inval;
    @(posedge clk);
    ll_rx_events <= '0;
    w = '0;
    w.tag = close_tag;  // closing entry has no payload
    rx_exp_q.push_back(w);
endtask

task automatic drain_d2h();
    fifo_word_t exp;
    int         guard;
    repeat (4) @(posedge clk);  // closing entry lands within 3 cycles
    @(negedge clk);
    if (rx_exp_q.size() >= `SATA_D2H_MANY_FILL) begin
        check_bit("d2h_many", d2h_many, 1'b1);
    end
    while (rx_exp_q.size() > 0) begin
        exp   = rx_exp_q.pop_front();
        guard = 0;
        @(negedge clk);
        while (!d2h_valid && (guard < WAIT_LIMIT)) begin
            @(negedge clk);
            guard++;
        end
        if (guard >= WAIT_LIMIT) begin
            report_timeout("d2h_valid");
            rx_exp_q.delete();
            break;
        end
        check_word("d2h_word", d2h_word, exp);
        @(posedge clk);
        d2h_ready <= 1'b1;
        @(posedge clk);
        d2h_ready <= 1'b0;
    end
    @(negedge clk);
    check_bit("d2h_valid", d2h_valid, 1'b0);
endtask

// fill both FIFOs and clear them with pcmd_st_cleared
task automatic flush_both(input int len);
    int idx;
    send_h2d_fis(len, H2D_FIS_LAST, idx);
    check_bit("ll_frame_req before last write", idx >= 0, 1'b0);
    wait_frame_req(1'b1);
    ack_frame();
    wait_frame_req(1'b0);
    recv_d2h_fis(len, 1'b0, D2H_R_OK);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_bit("ll_tx_valid before flush", ll_tx_valid, 1'b1);
    check_bit("d2h_valid before flush", d2h_valid, 1'b1);
    check_bit("d2h_many before flush", d2h_many, (len + 1) >= `SATA_D2H_MANY_FILL);
    @(posedge clk);
    pcmd_st_cleared <= 1'b1;
    @(posedge clk);
    pcmd_st_cleared <= 1'b0;
    @(negedge clk);
    check_bit("ll_tx_valid", ll_tx_valid, 1'b0);
    check_bit("d2h_valid", d2h_valid, 1'b0);
    check_bit("d2h_many", d2h_many, 1'b0);
    tx_exp_q.delete();
    rx_exp_q.delete();
endtask

`endif

// File: testbench/tb_sata_transport_bridge.sv
// SATA transport bridge testbench
// Runs a table of transmit, receive and flush tests against the bridge,
// checks every word that comes out of either FIFO against its own record
// of what went in, and ends with a count line

`include "sata_bridge_settings.svh"
`default_nettype none

module tb_sata_transport_bridge
    import sata_bridge_pkg::*;
();

    localparam int WAIT_LIMIT = 200;  // cycles per wait loop
    localparam int NUM_TESTS  = 7;

    localparam int KIND_TX    = 0;
    localparam int KIND_RX    = 1;
    localparam int KIND_FLUSH = 2;

    typedef struct {
        int         kind;     // KIND_TX, KIND_RX or KIND_FLUSH
        int         len;      // dwords in the FIS
        logic       inval;    // end receive with invalidate
        logic [1:0] exp_tag;  // tag of the final entry
    } test_row_t;

    logic                          clk;
    logic                          rst;
    logic                          pcmd_st_cleared;
    fifo_word_t                    h2d_word;
    logic                          h2d_valid;
    logic                          h2d_ready;
    fifo_word_t                    ll_tx_word;
    logic                          ll_tx_valid;
    logic                          ll_tx_last;
    logic                          ll_tx_strobe;
    logic                          ll_frame_req;
    logic                          ll_frame_ack;
    logic [`SATA_DWORD_WIDTH-1:0] ll_rx_data;
    logic [`SATA_MASK_WIDTH-1:0]  ll_rx_mask;
    logic                          ll_rx_valid;
    rx_events_t                    ll_rx_events;
    logic                          ll_rx_busy;
    fifo_word_t                    d2h_word;
    logic                          d2h_valid;
    logic                          d2h_many;
    logic                          d2h_ready;

    integer     seed;               // $random state
    int         errors;
    int         checks;
    int         test_errors;
    int         req_idx;            // write index where ll_frame_req was first seen
    test_row_t  rows [NUM_TESTS];
    fifo_word_t tx_exp_q [$];       // words expected on ll_tx_word
    fifo_word_t rx_exp_q [$];       // words expected on d2h_word

    sata_transport_bridge sata_transport_bridge_i (
        .clk             (clk),
        .rst             (rst),
        .pcmd_st_cleared (pcmd_st_cleared),
        .h2d_word        (h2d_word),
        .h2d_valid       (h2d_valid),
        .h2d_ready       (h2d_ready),
        .ll_tx_word      (ll_tx_word),
        .ll_tx_valid     (ll_tx_valid),
        .ll_tx_last      (ll_tx_last),
        .ll_tx_strobe    (ll_tx_strobe),
        .ll_frame_req    (ll_frame_req),
        .ll_frame_ack    (ll_frame_ack),
        .ll_rx_data      (ll_rx_data),
        .ll_rx_mask      (ll_rx_mask),
        .ll_rx_valid     (ll_rx_valid),
        .ll_rx_events    (ll_rx_events),
        .ll_rx_busy      (ll_rx_busy),
        .d2h_word        (d2h_word),
        .d2h_valid       (d2h_valid),
        .d2h_many        (d2h_many),
        .d2h_ready       (d2h_ready)
    );

    always #5 clk = ~clk;  // period 10

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        pcmd_st_cleared = 1'b0;
        h2d_word        = '0;
        h2d_valid       = 1'b0;
        ll_tx_strobe    = 1'b0;
        ll_frame_ack    = 1'b0;
        ll_rx_data      = '0;
        ll_rx_mask      = '0;
        ll_rx_valid     = 1'b0;
        ll_rx_events    = '0;
        d2h_ready       = 1'b0;
        seed            = 32'h8140_2ef4;
        errors          = 0;
        checks          = 0;
        req_idx         = -1;

        rows[0] = '{KIND_TX,    5,  1'b0, H2D_FIS_LAST};  // short FIS with last
        rows[1] = '{KIND_TX,    81, 1'b0, H2D_FIS_DATA};  // head + 80 data, no last
        rows[2] = '{KIND_RX,    12, 1'b0, D2H_R_OK};
        rows[3] = '{KIND_RX,    5,  1'b1, D2H_R_ERR};     // invalidated frame
        rows[4] = '{KIND_FLUSH, 10, 1'b0, 2'd0};          // enough D2H entries for d2h_many
        rows[5] = '{KIND_TX,    5,  1'b0, H2D_FIS_LAST};  // traffic after flush
        rows[6] = '{KIND_RX,    9,  1'b0, D2H_R_OK};

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // idle state after reset
        @(negedge clk);
        check_bit("ll_frame_req", ll_frame_req, 1'b0);
        check_bit("ll_tx_valid", ll_tx_valid, 1'b0);
        check_bit("d2h_valid", d2h_valid, 1'b0);
        check_bit("d2h_many", d2h_many, 1'b0);
        check_bit("ll_rx_busy", ll_rx_busy, 1'b0);
        check_bit("h2d_ready", h2d_ready, 1'b1);
        $display("reset test: %s", (errors == 0) ? "ok" : "failed");

        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = errors;
            case (rows[t].kind)
                KIND_TX: begin
                    send_h2d_fis(rows[t].len, rows[t].exp_tag, req_idx);
                    if (rows[t].exp_tag == H2D_FIS_LAST) begin
                        check_bit("ll_frame_req before last write", req_idx >= 0, 1'b0);
                    end else begin
                        check_bit("ll_frame_req before last write",
                                  (req_idx >= 0) && (req_idx < rows[t].len - 1), 1'b1);
                        // fill lags the write by one cycle, the request one more
                        check_bit("ll_frame_req at start fill",
                                  (req_idx >= 0) &&
                                  (req_idx <= `SATA_XMIT_START_FILL + 1), 1'b1);
                    end
                    wait_frame_req(1'b1);
                    ack_frame();
                    wait_frame_req(1'b0);  // falls after ack
                    drain_h2d();
                end
                KIND_RX: begin
                    recv_d2h_fis(rows[t].len, rows[t].inval, rows[t].exp_tag);
                    drain_d2h();
                end
                default: begin
                    flush_both(rows[t].len);
                end
            endcase
            $display("test %0d kind %0d len %0d: %s", t, rows[t].kind, rows[t].len,
                     (errors == test_errors) ? "ok" : "failed");
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    `include "tb_sata_transport_tasks.svh"

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
+incdir+testbench
source/sata_bridge_pkg.sv
source/sata_dword_fifo.sv
source/h2d_frame_scheduler.sv
source/d2h_fis_tagger.sv
source/sata_transport_bridge.sv
testbench/tb_sata_transport_bridge.sv
